//--- list.f
+incdir+hdl
hdl/aluPkg.sv
hdl/cmdControl.sv
hdl/arithUnit.sv
hdl/operandBank.sv
hdl/aluTop.sv
sim/aluChecker.sv
sim/aluTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the ALU testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module aluTb -o aluSim \
  > build.log 2>&1 \
  && ./obj_dir/aluSim > sim.log 2>&1 \
  || { echo "build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^TEST PASS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- sim/aluTb.sv
/* ALU testbench
   Clock, reset, seeded random commands and run limit for the ALU top level */

`timescale 1ns/10ps
`include "alu_consts.svh"

module aluTb;
  import aluPkg::*;

  localparam int numCmds = 400;
  // Gap, multiply steps and handshake per command plus reset margin
  localparam int cycleLimit = numCmds * 12 + 100;

  logic                   CLK = 1'b0;
  logic                   RST;
  aluCmdT                 cmd;
  logic                   cmdValid;
  logic                   cmdReady;
  logic [`ALU_DATA_W-1:0] rdData;
  aluStatusT              status;
  logic                   runEnd = 1'b0;
  logic                   reportDone;
  int                     failTotal;
  int                     seed = 85;
  int                     cycles = 0;

  // 40 ns clock
  always #20 CLK = ~CLK;

  aluTop u_aluTop
  (
    .CLK      (CLK),
    .RST      (RST),
    .cmd      (cmd),
    .cmdValid (cmdValid),
    .cmdReady (cmdReady),
    .rdData   (rdData),
    .status   (status)
  );

  aluChecker u_aluChecker
  (
    .CLK        (CLK),
    .RST        (RST),
    .cmd        (cmd),
    .cmdValid   (cmdValid),
    .cmdReady   (cmdReady),
    .rdData     (rdData),
    .status     (status),
    .runEnd     (runEnd),
    .reportDone (reportDone),
    .failTotal  (failTotal)
  );

  ////////////////////
  // Run limit

  always @(posedge CLK)
  begin
    cycles = cycles + 1;
    if (cycles >= cycleLimit)
    begin
      $display("timeout: run did not finish within %0d cycles", cycleLimit);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////
  // Random commands

  // Roughly one read select in three and multiply the rarest
  task automatic makeCommand(output aluCmdT c);
    logic [31:0] bits;
    int unsigned opPick;
    opPick = $unsigned($random(seed)) % 12;
    bits = $random(seed);
    if (opPick < 4)
      c.op = OP_READSEL;
    else if (opPick < 7)
      c.op = OP_LOAD;
    else if (opPick < 9)
      c.op = OP_ADD;
    else if (opPick < 11)
      c.op = OP_SUB;
    else
      c.op = OP_MUL;
    c.regSel  = bits[0];
    c.byteSel = bits[1];
    c.srcA    = bits[2];
    c.data    = bits[15:8];
  endtask

  initial
  begin
    aluCmdT nextCmd;
    int     gap;
    RST      <= 1'b0;
    cmd      <= '0;
    cmdValid <= 1'b0;
    repeat (10) @(posedge CLK);
    RST <= 1'b1;
    @(posedge CLK);
    for (int i = 0; i < numCmds; i++)
    begin
      gap = $unsigned($random(seed)) % 4;
      // Idle cycles carry junk on the command bus
      repeat (gap)
      begin
        makeCommand(nextCmd);
        cmd      <= nextCmd;
        cmdValid <= 1'b0;
        @(posedge CLK);
      end
      makeCommand(nextCmd);
      cmd      <= nextCmd;
      cmdValid <= 1'b1;
      // Hold until ready as sampled mid-cycle
      @(negedge CLK);
      while (!cmdReady)
      begin
        @(negedge CLK);
      end
      // Acceptance edge
      @(posedge CLK);
    end
    cmdValid <= 1'b0;
    // Drain a trailing multiply and its done pulse
    @(negedge CLK);
    while (status.busy || status.done)
    begin
      @(negedge CLK);
    end
    repeat (2) @(negedge CLK);
    // Summary starts away from the checker's sampling edge
    @(posedge CLK);
    runEnd = 1'b1;
    wait (reportDone);
    if (failTotal == 0)
    begin
      $display("TEST PASS");
    end
    else
    begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- sim/aluChecker.sv
/* ALU checker
   Port-level model of registers, flags and sequencing, compared every cycle */

`timescale 1ns/10ps
`include "alu_consts.svh"

module aluChecker
(
  input  logic                   CLK,
  input  logic                   RST,
  input  aluPkg::aluCmdT         cmd,
  input  logic                   cmdValid,
  input  logic                   cmdReady,
  input  logic [`ALU_DATA_W-1:0] rdData,
  input  aluPkg::aluStatusT      status,
  input  logic                   runEnd,
  output logic                   reportDone,
  output int                     failTotal
);
  import aluPkg::*;

  localparam int dataW     = `ALU_DATA_W;
  localparam int regW      = `ALU_REG_W;
  localparam int numGroups = 6;
  // Behavior groups
  localparam int grpRead  = 0;
  localparam int grpAdd   = 1;
  localparam int grpSub   = 2;
  localparam int grpMul   = 3;
  localparam int grpTime  = 4;
  localparam int grpReset = 5;

  string groupName [numGroups] = '{"byte loads and read select", "add", "subtract",
                                   "multiply result", "multiply timing", "reset state"};
  int    passCnt [numGroups] = '{default: 0};
  int    failCnt [numGroups] = '{default: 0};

  // Model of the DUT state
  logic [regW-1:0]  modA;
  logic [regW-1:0]  modB;
  logic             selB;
  logic             selHigh;
  logic             modCarry;
  logic             modBorrow;
  logic             modBusy;
  logic             modDone;
  int               modStep;
  logic [dataW-1:0] mulA;
  logic [dataW-1:0] mulD;
  // Which group owns B, the flags and done
  int               bGroup;
  int               flagGroup;
  int               doneGroup;
  logic             inReset;
  logic             reportFlag = 1'b0;
  int               failSum = 0;

  assign reportDone = reportFlag;
  assign failTotal  = failSum;

  task automatic checkValue(input int grp, input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got === exp)
    begin
      passCnt[grp]++;
    end
    else
    begin
      failCnt[grp]++;
      $display("mismatch at %0t: %s is %0h, expected %0h (%s)", $time, what, got, exp,
               groupName[grp]);
    end
  endtask

  // Until the first command, everything counts as reset state
  function automatic int groupFor(input int grp);
    return inReset ? grpReset : grp;
  endfunction

  task automatic resetModel();
    modA      = '0;
    modB      = '0;
    selB      = 1'b0;
    selHigh   = 1'b0;
    modCarry  = 1'b0;
    modBorrow = 1'b0;
    modBusy   = 1'b0;
    modDone   = 1'b0;
    modStep   = 0;
    bGroup    = grpRead;
    flagGroup = grpReset;
    doneGroup = grpTime;
    inReset   = 1'b1;
  endtask

  ////////////////////
  // Output comparison

  task automatic compareOutputs();
    logic [regW-1:0]  selReg;
    logic [dataW-1:0] expByte;
    selReg  = selB ? modB : modA;
    expByte = selHigh ? selReg[regW-1:dataW] : selReg[dataW-1:0];
    checkValue(groupFor(selB ? bGroup : grpRead), "rdData", rdData, expByte);
    checkValue(groupFor(grpTime), "cmdReady", cmdReady, !modBusy);
    checkValue(groupFor(grpTime), "busy", status.busy, modBusy);
    checkValue(groupFor(doneGroup), "done", status.done, modDone);
    checkValue(groupFor(flagGroup), "carry", status.carry, modCarry);
    checkValue(groupFor(flagGroup), "borrow", status.borrow, modBorrow);
  endtask

  ////////////////////
  // Next edge of the model

  task automatic advanceModel();
    logic [regW:0]   wide;
    logic [regW-1:0] operand;
    int              mask;
    int              product;
    modDone = 1'b0;
    operand = cmd.srcA ? modA : {{(regW-dataW){1'b0}}, cmd.data};
    if (modBusy)
    begin
      // B is the product over the multiplier bits used so far
      mask    = (1 << (modStep + 1)) - 1;
      product = mulA * (mulD & mask);
      modB    = product[regW-1:0];
      if (modStep == `ALU_MUL_STEPS - 1)
      begin
        modBusy   = 1'b0;
        modDone   = 1'b1;
        doneGroup = grpTime;
      end
      modStep++;
    end
    else if (cmdValid)
    begin
      inReset = 1'b0;
      case (cmd.op)
        OP_LOAD:
        begin
          if (cmd.regSel)
          begin
            bGroup = grpRead;
            if (cmd.byteSel)
              modB[regW-1:dataW] = cmd.data;
            else
              modB[dataW-1:0] = cmd.data;
          end
          else if (cmd.byteSel)
            modA[regW-1:dataW] = cmd.data;
          else
            modA[dataW-1:0] = cmd.data;
        end
        OP_READSEL:
        begin
          selB    = cmd.regSel;
          selHigh = cmd.byteSel;
        end
        OP_ADD:
        begin
          wide      = {1'b0, modB} + {1'b0, operand};
          modB      = wide[regW-1:0];
          modCarry  = wide[regW];
          modBorrow = 1'b0;
          modDone   = 1'b1;
          bGroup    = grpAdd;
          flagGroup = grpAdd;
          doneGroup = grpAdd;
        end
        OP_SUB:
        begin
          // Borrow when the operand is larger
          modBorrow = (operand > modB);
          modB      = modB - operand;
          modCarry  = 1'b0;
          modDone   = 1'b1;
          bGroup    = grpSub;
          flagGroup = grpSub;
          doneGroup = grpSub;
        end
        OP_MUL:
        begin
          modBusy   = 1'b1;
          modStep   = 0;
          mulA      = modA[dataW-1:0];
          mulD      = cmd.data;
          modB      = '0;
          modCarry  = 1'b0;
          modBorrow = 1'b0;
          bGroup    = grpMul;
          flagGroup = grpMul;
        end
        default:
        begin
        end
      endcase
    end
  endtask

  // Outputs settled and inputs fixed at mid-cycle
  always @(negedge CLK)
  begin
    if (!RST)
    begin
      resetModel();
    end
    compareOutputs();
    if (RST)
    begin
      advanceModel();
    end
  end

  ////////////////////
  // Summary

  always @(posedge runEnd)
  begin
    int passAll;
    int failAll;
    passAll = 0;
    failAll = 0;
    for (int g = 0; g < numGroups; g++)
    begin
      passAll += passCnt[g];
      failAll += failCnt[g];
      if (passCnt[g] + failCnt[g] == 0)
      begin
        $display("%s: no checks ran for this group", groupName[g]);
        failAll++;
      end
      else
      begin
        $display("%-28s %s (%0d passed, %0d failed)", groupName[g],
                 (failCnt[g] == 0) ? "ok" : "wrong", passCnt[g], failCnt[g]);
      end
    end
    $display("checks: %0d passed, %0d failed", passAll, failAll);
    failSum    = failAll;
    reportFlag = 1'b1;
  end

endmodule

//--- hdl/aluTop.sv
/* ALU top level
   Joins control, operand bank and adder, drives the read byte */

`timescale 1ns/10ps
`include "alu_consts.svh"

module aluTop
(
  input  logic                     CLK,
  input  logic                     RST,
  input  aluPkg::aluCmdT           cmd,
  input  logic                     cmdValid,
  output logic                     cmdReady,
  output logic [`ALU_DATA_W-1:0]   rdData,
  output aluPkg::aluStatusT        status
);
  import aluPkg::*;

  aluCtrlT                    ctrl;
  readSelT                    readSel;
  logic [`ALU_REG_W-1:0]      regA;
  logic [`ALU_REG_W-1:0]      regB;
  logic [`ALU_REG_W-1:0]      sum;
  logic [`ALU_STEP_CNT_W-1:0] stepIdx;
  logic                       carryOut;
  logic                       mulBit;
  logic                       busy;
  logic                       done;
  logic                       carry;
  logic                       borrow;

  cmdControl u_cmdControl
  (
    .CLK      (CLK),
    .RST      (RST),
    .cmd      (cmd),
    .cmdValid (cmdValid),
    .cmdReady (cmdReady),
    .ctrl     (ctrl),
    .readSel  (readSel),
    .stepIdx  (stepIdx),
    .busy     (busy),
    .done     (done)
  );

  arithUnit u_arithUnit
  (
    .ctrl     (ctrl),
    .regA     (regA),
    .regB     (regB),
    .mulBit   (mulBit),
    .stepIdx  (stepIdx),
    .sum      (sum),
    .carryOut (carryOut)
  );

  operandBank u_operandBank
  (
    .CLK      (CLK),
    .RST      (RST),
    .ctrl     (ctrl),
    .sum      (sum),
    .carryOut (carryOut),
    .regA     (regA),
    .regB     (regB),
    .mulBit   (mulBit),
    .carry    (carry),
    .borrow   (borrow)
  );

  assign status = '{busy: busy, done: done, carry: carry, borrow: borrow};

  // Read byte mux in A low/high then B low/high order
  always_comb
  begin
    case ({readSel.regSel, readSel.byteSel})
      2'b00:   rdData = regA[`ALU_DATA_W-1:0];
      2'b01:   rdData = regA[`ALU_REG_W-1:`ALU_DATA_W];
      2'b10:   rdData = regB[`ALU_DATA_W-1:0];
      default: rdData = regB[`ALU_REG_W-1:`ALU_DATA_W];
    endcase
  end

endmodule

//--- hdl/operandBank.sv
/* Operand bank
   Registers A and B, multiplier shift register and result flags */

`timescale 1ns/10ps
`include "alu_consts.svh"

module operandBank
(
  input  logic                    CLK,
  input  logic                    RST,
  input  aluPkg::aluCtrlT         ctrl,
  input  logic [`ALU_REG_W-1:0]   sum,
  input  logic                    carryOut,
  output logic [`ALU_REG_W-1:0]   regA,
  output logic [`ALU_REG_W-1:0]   regB,
  output logic                    mulBit,
  output logic                    carry,
  output logic                    borrow
);

  localparam int dataW = `ALU_DATA_W;
  localparam int regW  = `ALU_REG_W;

  logic             arithWrite;
  logic [dataW-1:0] mulShift;

  // Adder result lands in B on ADD, SUB and each multiply step
  assign arithWrite = ctrl.arithEn | ctrl.mulStep;

  // Current multiplier bit
  assign mulBit = mulShift[0];

  ////////////////////
  // Register A

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      regA <= '0;
    end
    else if (ctrl.loadEn && !ctrl.regSel)
    begin
      if (ctrl.byteSel)
      begin
        regA[regW-1:dataW] <= ctrl.loadData;
      end
      else
      begin
        regA[dataW-1:0] <= ctrl.loadData;
      end
    end
  end

  ////////////////////
  // Register B

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      regB <= '0;
    end
    else if (ctrl.loadEn && ctrl.regSel)
    begin
      if (ctrl.byteSel)
      begin
        regB[regW-1:dataW] <= ctrl.loadData;
      end
      else
      begin
        regB[dataW-1:0] <= ctrl.loadData;
      end
    end
    // Product accumulates from zero
    else if (ctrl.mulStart)
    begin
      regB <= '0;
    end
    else if (arithWrite)
    begin
      regB <= sum;
    end
  end

  ////////////////////
  // Flags

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      carry  <= 1'b0;
      borrow <= 1'b0;
    end
    else if (ctrl.arithEn)
    begin
      // SUB adds the complement, so no carry out means borrow
      carry  <= ~ctrl.subtract & carryOut;
      borrow <= ctrl.subtract & ~carryOut;
    end
    else if (ctrl.mulStart)
    begin
      carry  <= 1'b0;
      borrow <= 1'b0;
    end
  end

  // Multiplier shifts right with the LSB first
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      mulShift <= '0;
    end
    else if (ctrl.mulStart)
    begin
      mulShift <= ctrl.operand;
    end
    else if (ctrl.mulStep)
    begin
      mulShift <= mulShift >> 1;
    end
  end

  // Decoder never mixes a byte load with a B update
  aLoadArithExcl: assert property (@(posedge CLK) disable iff (!RST)
    !(ctrl.loadEn && (arithWrite || ctrl.mulStart)));

endmodule

//--- hdl/arithUnit.sv
/* Arithmetic unit
   Operand select and 16-bit adder for ADD, SUB and multiply steps */

`timescale 1ns/10ps
`include "alu_consts.svh"

module arithUnit
(
  input  aluPkg::aluCtrlT             ctrl,
  input  logic [`ALU_REG_W-1:0]       regA,
  input  logic [`ALU_REG_W-1:0]       regB,
  input  logic                        mulBit,
  input  logic [`ALU_STEP_CNT_W-1:0]  stepIdx,
  output logic [`ALU_REG_W-1:0]       sum,
  output logic                        carryOut
);

  localparam int dataW = `ALU_DATA_W;
  localparam int regW  = `ALU_REG_W;

  logic [regW-1:0] baseOp;
  logic [regW-1:0] partial;
  logic [regW-1:0] addOp;
  logic            carryIn;

  // A low byte weighted by the step index
  assign partial = {{(regW-dataW){1'b0}}, regA[dataW-1:0]} << stepIdx;

  always_comb
  begin
    // Register A or zero-extended data byte
    baseOp = ctrl.srcA ? regA : {{(regW-dataW){1'b0}}, ctrl.operand};
    if (ctrl.mulStep)
    begin
      // Skip the partial product on a zero multiplier bit
      addOp   = mulBit ? partial : '0;
      carryIn = 1'b0;
    end
    else if (ctrl.subtract)
    begin
      // Two's complement subtract
      addOp   = ~baseOp;
      carryIn = 1'b1;
    end
    else
    begin
      addOp   = baseOp;
      carryIn = 1'b0;
    end
  end

  // 17-bit add keeps the carry
  assign {carryOut, sum} = {1'b0, regB} + {1'b0, addOp} + {{regW{1'b0}}, carryIn};

endmodule

//--- hdl/cmdControl.sv
/* Command control
   Accepts commands, decodes them into one cycle of control, sequences multiply */

`timescale 1ns/10ps
`include "alu_consts.svh"

module cmdControl
(
  input  logic                        CLK,
  input  logic                        RST,
  input  aluPkg::aluCmdT              cmd,
  input  logic                        cmdValid,
  output logic                        cmdReady,
  output aluPkg::aluCtrlT             ctrl,
  output aluPkg::readSelT             readSel,
  output logic [`ALU_STEP_CNT_W-1:0]  stepIdx,
  output logic                        busy,
  output logic                        done
);
  import aluPkg::*;

  // Index of the last multiply step
  localparam int lastStepIdx = `ALU_MUL_STEPS - 1;

  logic                       accept;
  logic                       arithAccept;
  logic                       mulAccept;
  logic                       finalStep;
  logic [`ALU_STEP_CNT_W-1:0] stepCnt;

  ////////////////////
  // Handshake and decode

  // Only a running multiply stalls the command port
  assign cmdReady    = ~busy;
  assign accept      = cmdValid & cmdReady;
  assign arithAccept = accept & ((cmd.op == OP_ADD) | (cmd.op == OP_SUB));
  assign mulAccept   = accept & (cmd.op == OP_MUL);

  // Last shift-and-add cycle
  assign finalStep = busy & (stepCnt == lastStepIdx[`ALU_STEP_CNT_W-1:0]);
  assign stepIdx   = stepCnt;

  always_comb
  begin
    // Byte load path
    ctrl.loadEn   = accept & (cmd.op == OP_LOAD);
    ctrl.regSel   = cmd.regSel;
    ctrl.byteSel  = cmd.byteSel;
    ctrl.loadData = cmd.data;
    // Add/subtract path applied at the acceptance edge
    ctrl.arithEn  = arithAccept;
    ctrl.subtract = (cmd.op == OP_SUB);
    ctrl.srcA     = cmd.srcA;
    ctrl.operand  = cmd.data;
    // Multiply start then one step per busy cycle
    ctrl.mulStart = mulAccept;
    ctrl.mulStep  = busy;
  end

  ////////////////////
  // Multiply sequencer and done pulse

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      busy    <= 1'b0;
      stepCnt <= '0;
      done    <= 1'b0;
    end
    else
    begin
      // One cycle after ADD/SUB or after the last step
      done <= arithAccept | finalStep;
      if (mulAccept)
      begin
        busy    <= 1'b1;
        stepCnt <= '0;
      end
      else if (busy)
      begin
        // Counter parks at the step count until the next multiply
        stepCnt <= stepCnt + 1'b1;
        if (finalStep)
        begin
          busy <= 1'b0;
        end
      end
    end
  end

  ////////////////////
  // Read select register

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      // A low byte after reset
      readSel <= '0;
    end
    else if (accept && (cmd.op == OP_READSEL))
    begin
      readSel.regSel  <= cmd.regSel;
      readSel.byteSel <= cmd.byteSel;
    end
  end

  ////////////////////
  // Checks

  // Multiply blocks the command port for all its steps
  aMulNoAccept: assert property (@(posedge CLK) disable iff (!RST)
    mulAccept |=> (!accept) [*`ALU_MUL_STEPS]);

  // Counter stays within the step range
  aStepRange: assert property (@(posedge CLK) disable iff (!RST)
    stepCnt <= `ALU_MUL_STEPS);

  // Done only once the sequencer is idle
  aDoneIdle: assert property (@(posedge CLK) disable iff (!RST)
    !(done && busy));

endmodule

//--- hdl/aluPkg.sv
/* ALU shared types
   Opcodes plus the command, control, status and read-select bundles */

`include "alu_consts.svh"

package aluPkg;

  // Command opcodes
  typedef enum logic [2:0]
  {
    OP_LOAD    = 3'd0,
    OP_READSEL = 3'd1,
    OP_ADD     = 3'd2,
    OP_SUB     = 3'd3,
    OP_MUL     = 3'd4
  } aluOpT;

  // Command as presented on the input handshake
  typedef struct packed
  {
    aluOpT                  op;
    // 0 picks A, 1 picks B
    logic                   regSel;
    // 0 picks low byte, 1 high byte
    logic                   byteSel;
    // ADD/SUB operand from A instead of data byte
    logic                   srcA;
    logic [`ALU_DATA_W-1:0] data;
  } aluCmdT;

  // Per-cycle control out of the command decoder
  typedef struct packed
  {
    logic                   loadEn;
    logic                   regSel;
    logic                   byteSel;
    logic [`ALU_DATA_W-1:0] loadData;
    logic                   arithEn;
    logic                   subtract;
    logic                   srcA;
    logic [`ALU_DATA_W-1:0] operand;
    logic                   mulStart;
    logic                   mulStep;
  } aluCtrlT;

  // Visible status bits
  typedef struct packed
  {
    logic busy;
    logic done;
    logic carry;
    logic borrow;
  } aluStatusT;

  // Which register byte drives the read port
  typedef struct packed
  {
    logic regSel;
    logic byteSel;
  } readSelT;

endpackage

//--- hdl/alu_consts.svh
/* ALU sizing constants
   Byte bus, register and multiply sequencing widths */

`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// Byte bus and multiplier operand width
`define ALU_DATA_W 8

// Registers A, B and the adder
`define ALU_REG_W 16

// Shift-and-add multiply sequencing
`define ALU_MUL_STEPS 8
`define ALU_STEP_CNT_W 4

`endif
